// ==== hdl/busPkg.sv ====
/*
 * Bus bridge shared types
 * Request encoding, AHB-Lite transfer types, the bundled AHB control
 * word and HBURST codes used by the bridge and its bench
 */
`default_nettype none

package busPkg;

  // Bit 1 requests a read (fetch), bit 0 a write (evict), zero is no request
  typedef logic [1:0] busRwT;

  // AHB-Lite HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } ahbTransT;

  // Address phase control, split onto HTRANS, HWRITE and HBURST at the top
  typedef struct packed {
    ahbTransT   trans;
    logic       write;
    logic [2:0] burst;
  } ahbCtrlT;

  // HBURST codes
  localparam logic [2:0] burstSingle = 3'b000;
  localparam logic [2:0] burstIncr   = 3'b001;
  localparam logic [2:0] burstIncr4  = 3'b011;
  localparam logic [2:0] burstIncr8  = 3'b101;
  localparam logic [2:0] burstIncr16 = 3'b111;

endpackage

`default_nettype wire

// ==== hdl/busCacheFsm.sv ====
/*
 * Bus sequencing FSM
 * Runs single uncached accesses and cache line bursts on AHB-Lite,
 * with address and data phase word counters, stall, commit and ack
 */
`timescale 1ns/1ps
`default_nettype none

module busCacheFsm #(
  parameter int wordsPerLine = 4
) (
  input  wire logic                              HCLK,
  input  wire logic                              HRESETn,
  input  wire busPkg::busRwT                     busRw,
  input  wire logic                              cpuBusy,
  input  wire busPkg::busRwT                     cacheBusRw,
  input  wire logic                              HREADY,
  output logic                                   busCommitted,
  output logic                                   busStall,
  output logic                                   captureEn,
  output logic                                   cacheBusAck,
  output logic                                   selUncachedAdr,
  output logic                                   selBusWord,
  output logic [$clog2(wordsPerLine)-1:0]        wordCount,
  output logic [$clog2(wordsPerLine)-1:0]        wordCountDelayed,
  output busPkg::ahbCtrlT                        ahbCtrl
);

  localparam int logWpl = $clog2(wordsPerLine);

  typedef enum logic [2:0] {
    adrPhase,
    dataPhase,
    memHold,
    cacheFetch,
    cacheEvict
  } stateT;

  stateT       state;
  stateT       nextState;
  logic        cacheAccess;
  logic        finalWord;
  logic        cntEn;
  logic        cntClr;
  logic [2:0]  lineBurst;

  ////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      state <= adrPhase;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      // Uncached traffic wins over line transfers
      adrPhase: begin
        if (HREADY && |busRw) nextState = dataPhase;
        else if (HREADY && cacheBusRw[0]) nextState = cacheEvict;
        else if (HREADY && cacheBusRw[1]) nextState = cacheFetch;
      end
      dataPhase: begin
        if (HREADY) nextState = memHold;
      end
      // Hold result until the CPU can take it
      memHold: begin
        if (!cpuBusy) nextState = adrPhase;
      end
      cacheFetch, cacheEvict: begin
        // Last data phase done, chain straight into a pending request
        if (HREADY && finalWord) begin
          if (cacheBusRw[0]) nextState = cacheEvict;
          else if (cacheBusRw[1]) nextState = cacheFetch;
          else nextState = adrPhase;
        end
      end
      default: nextState = adrPhase;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Word counters
  ////////////////////////////////////////////////////////////

  // wordCount follows the address phase, wordCountDelayed the data phase
  assign cacheAccess = (state == cacheFetch) || (state == cacheEvict);
  assign cntClr = (nextState == adrPhase);
  assign cntEn = HREADY && (cacheAccess ||
                 ((state == adrPhase) && !(|busRw) && |cacheBusRw));

  always_ff @(posedge HCLK) begin
    if (!HRESETn || cntClr) begin
      wordCount        <= '0;
      wordCountDelayed <= '0;
    end else if (cntEn) begin
      // Wraps to zero after the last address phase
      wordCount        <= wordCount + 1'b1;
      wordCountDelayed <= wordCount;
    end
  end

  assign finalWord = (wordCountDelayed == logWpl'(wordsPerLine - 1));

  ////////////////////////////////////////////////////////////
  // Status toward CPU, cache and data path
  ////////////////////////////////////////////////////////////

  assign busStall = ((state == adrPhase) && (|busRw || |cacheBusRw)) ||
                    (state == dataPhase) || cacheAccess;
  assign busCommitted = (state != adrPhase);
  assign selUncachedAdr = ((state == adrPhase) && |busRw) ||
                          (state == dataPhase) || (state == memHold);
  assign selBusWord = cacheAccess;
  // Sample HRDATA on each completing read data phase
  assign captureEn = HREADY && (((state == dataPhase) && busRw[1]) ||
                                (state == cacheFetch));
  assign cacheBusAck = cacheAccess && HREADY && finalWord;

  ////////////////////////////////////////////////////////////
  // AHB control
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (wordsPerLine)
      4:       lineBurst = busPkg::burstIncr4;
      8:       lineBurst = busPkg::burstIncr8;
      16:      lineBurst = busPkg::burstIncr16;
      default: lineBurst = busPkg::burstIncr;
    endcase
  end

  always_comb begin
    ahbCtrl.trans = busPkg::IDLE;
    ahbCtrl.write = 1'b0;
    ahbCtrl.burst = busPkg::burstSingle;
    if (state == adrPhase) begin
      if (|busRw) begin
        ahbCtrl.trans = busPkg::NONSEQ;
        ahbCtrl.write = busRw[0];
      end else if (|cacheBusRw) begin
        ahbCtrl.trans = busPkg::NONSEQ;
        ahbCtrl.write = cacheBusRw[0];
        ahbCtrl.burst = lineBurst;
      end
    end else if (cacheAccess) begin
      if (wordCount != '0) begin
        // Remaining beats of the current line
        ahbCtrl.trans = busPkg::SEQ;
        ahbCtrl.write = (state == cacheEvict);
        ahbCtrl.burst = lineBurst;
      end else if (finalWord && HREADY && |cacheBusRw) begin
        // Next line overlaps the last data phase
        ahbCtrl.trans = busPkg::NONSEQ;
        ahbCtrl.write = cacheBusRw[0];
        ahbCtrl.burst = lineBurst;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/busAddrGen.sv ====
/*
 * AHB address generator
 * Picks the word aligned CPU address for uncached accesses, or the line
 * base with the burst word index for cache line transfers
 */
`timescale 1ns/1ps
`default_nettype none

module busAddrGen #(
  parameter int xlen         = 32,
  parameter int wordsPerLine = 4
) (
  input  wire logic [xlen-1:0]                 cpuAdr,
  input  wire logic [xlen-1:0]                 cacheLineAdr,
  input  wire logic                            selUncachedAdr,
  input  wire logic [$clog2(wordsPerLine)-1:0] wordCount,
  output logic [xlen-1:0]                      HADDR
);

  localparam int logWpl  = $clog2(wordsPerLine);
  // Byte offset bits within one word
  localparam int offBits = $clog2(xlen / 8);

  logic [xlen-1:0] uncachedAdr;
  logic [xlen-1:0] lineWordAdr;

  // Full word transfers only, drop the byte offset
  assign uncachedAdr = {cpuAdr[xlen-1:offBits], {offBits{1'b0}}};

  // Word index sits right above the byte offset
  assign lineWordAdr = {cacheLineAdr[xlen-1:offBits+logWpl],
                        wordCount,
                        {offBits{1'b0}}};

  assign HADDR = selUncachedAdr ? uncachedAdr : lineWordAdr;

endmodule

`default_nettype wire

// ==== hdl/busDataPath.sv ====
/*
 * Bridge data path
 * Captures read words into the line buffer or the uncached read register
 * and selects the write word for each data phase
 */
`timescale 1ns/1ps
`default_nettype none

module busDataPath #(
  parameter int xlen         = 32,
  parameter int wordsPerLine = 4
) (
  input  wire logic                              HCLK,
  input  wire logic                              HRESETn,
  input  wire logic [xlen-1:0]                   HRDATA,
  input  wire logic                              captureEn,
  input  wire logic                              selBusWord,
  input  wire busPkg::busRwT                     busRw,
  input  wire logic [$clog2(wordsPerLine)-1:0]   wordCountDelayed,
  input  wire logic [xlen-1:0]                   cpuWriteData,
  input  wire logic [wordsPerLine*xlen-1:0]      evictLine,
  output logic [xlen-1:0]                        HWDATA,
  output logic [xlen-1:0]                        readData,
  output logic [wordsPerLine*xlen-1:0]           fetchedLine
);

  // Fetched words, indexed by data phase word count
  logic [wordsPerLine-1:0][xlen-1:0] lineBuf;

  ////////////////////////////////////////////////////////////
  // Read capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (captureEn && selBusWord) begin
      lineBuf[wordCountDelayed] <= HRDATA;
    end
  end

  // Uncached read result, kept until the next uncached read lands
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      readData <= '0;
    end else if (captureEn && !selBusWord && busRw[1]) begin
      readData <= HRDATA;
    end
  end

  assign fetchedLine = lineBuf;

  ////////////////////////////////////////////////////////////
  // Write data
  ////////////////////////////////////////////////////////////

  // Evict word follows the data phase, not the address phase
  assign HWDATA = selBusWord ? evictLine[wordCountDelayed*xlen +: xlen] : cpuWriteData;

endmodule

`default_nettype wire

// ==== hdl/busBridge.sv ====
/*
 * Load/store bus bridge top level
 * Connects the bus FSM, address generator and data path between the
 * CPU and cache request ports and one AHB-Lite master port
 */
`timescale 1ns/1ps
`default_nettype none

module busBridge #(
  parameter int xlen         = 32,
  parameter int wordsPerLine = 4
) (
  input  wire logic                          HCLK,
  input  wire logic                          HRESETn,
  // CPU side
  input  wire busPkg::busRwT                 busRw,
  input  wire logic [xlen-1:0]               cpuAdr,
  input  wire logic [xlen-1:0]               cpuWriteData,
  input  wire logic                          cpuBusy,
  output logic                               busStall,
  output logic                               busCommitted,
  output logic [xlen-1:0]                    readData,
  // Cache side
  input  wire busPkg::busRwT                 cacheBusRw,
  input  wire logic [xlen-1:0]               cacheLineAdr,
  input  wire logic [wordsPerLine*xlen-1:0]  evictLine,
  output logic                               cacheBusAck,
  output logic [wordsPerLine*xlen-1:0]       fetchedLine,
  // AHB-Lite master
  output logic [xlen-1:0]                    HADDR,
  output busPkg::ahbTransT                   HTRANS,
  output logic                               HWRITE,
  output logic [2:0]                         HBURST,
  output logic [xlen-1:0]                    HWDATA,
  input  wire logic [xlen-1:0]               HRDATA,
  input  wire logic                          HREADY
);

  localparam int logWpl = $clog2(wordsPerLine);

  busPkg::ahbCtrlT   ahbCtrl;
  logic              captureEn;
  logic              selUncachedAdr;
  logic              selBusWord;
  logic [logWpl-1:0] wordCount;
  logic [logWpl-1:0] wordCountDelayed;

  busCacheFsm #(.wordsPerLine(wordsPerLine)) busCacheFsm_i (
    .HCLK, .HRESETn, .busRw, .cpuBusy, .cacheBusRw, .HREADY,
    .busCommitted, .busStall, .captureEn, .cacheBusAck,
    .selUncachedAdr, .selBusWord, .wordCount, .wordCountDelayed, .ahbCtrl
  );

  busAddrGen #(.xlen(xlen), .wordsPerLine(wordsPerLine)) busAddrGen_i (
    .cpuAdr, .cacheLineAdr, .selUncachedAdr, .wordCount, .HADDR
  );

  busDataPath #(.xlen(xlen), .wordsPerLine(wordsPerLine)) busDataPath_i (
    .HCLK, .HRESETn, .HRDATA, .captureEn, .selBusWord, .busRw,
    .wordCountDelayed, .cpuWriteData, .evictLine,
    .HWDATA, .readData, .fetchedLine
  );

  // Split the control word onto the AHB pins
  assign HTRANS = ahbCtrl.trans;
  assign HWRITE = ahbCtrl.write;
  assign HBURST = ahbCtrl.burst;

endmodule

`default_nettype wire

// ==== bench/ahbMemModel.sv ====
/*
 * AHB-Lite slave memory model
 * 256 words with pseudo-random wait states on every data phase
 */
`timescale 1ns/1ps
`default_nettype none

module ahbMemModel #(
  parameter int maxWait = 3
) (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,
  input  wire logic [31:0]      HADDR,
  input  wire busPkg::ahbTransT HTRANS,
  input  wire logic             HWRITE,
  input  wire logic [31:0]      HWDATA,
  output logic [31:0]           HRDATA,
  output logic                  HREADY
);

  logic [31:0] mem [256];
  logic        dpValid;
  logic        dpWrite;
  logic [7:0]  dpIdx;
  logic [31:0] waitLeft;
  logic [31:0] rngState;

  function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Fill pattern mixes every address bit
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h9E37_79B1);
    end
  end

  always @(posedge HCLK) begin
    if (!HRESETn) begin
      dpValid  <= 1'b0;
      dpWrite  <= 1'b0;
      dpIdx    <= '0;
      waitLeft <= '0;
      rngState <= 32'd33711;
    end else if (HREADY) begin
      // Data phase ends here, write lands now
      if (dpValid && dpWrite) begin
        mem[dpIdx] <= HWDATA;
      end
      dpValid <= HTRANS[1];
      dpWrite <= HWRITE;
      dpIdx   <= HADDR[9:2];
      rngState <= xorshiftStep(rngState);
      waitLeft <= HTRANS[1] ? rngState % 32'(maxWait + 1) : '0;
    end else begin
      waitLeft <= waitLeft - 32'd1;
    end
  end

  assign HREADY = !dpValid || (waitLeft == '0);
  assign HRDATA = (dpValid && !dpWrite) ? mem[dpIdx] : '0;

endmodule

`default_nettype wire

// ==== bench/busBridgeTb.sv ====
/*
 * Bus bridge testbench
 * Uncached reads and writes, line fill, eviction and chained transfers
 * against an AHB memory model with random wait states
 */
`timescale 1ns/1ps
`default_nettype none

module busBridgeTb;

  localparam int wpl         = 4;
  localparam int maxWait     = 3;
  // 3 uncached accesses plus 4 lines of 4 words
  localparam int numAccesses = 3 + 4 * wpl;
  localparam int cycleLimit  = 20 * numAccesses * (1 + maxWait);

  typedef struct packed {
    logic [31:0]      addr;
    busPkg::ahbTransT trans;
    logic             write;
    logic [2:0]       burst;
  } adrPhaseT;

  logic HCLK = 1'b0;
  logic HRESETn;
  busPkg::busRwT busRw;
  logic [31:0] cpuAdr;
  logic [31:0] cpuWriteData;
  logic cpuBusy;
  busPkg::busRwT cacheBusRw;
  logic [31:0] cacheLineAdr;
  logic [wpl*32-1:0] evictLine;
  wire logic busStall;
  wire logic busCommitted;
  wire logic [31:0] readData;
  wire logic cacheBusAck;
  wire logic [wpl*32-1:0] fetchedLine;
  wire logic [31:0] HADDR;
  busPkg::ahbTransT HTRANS;
  wire logic HWRITE;
  wire logic [2:0] HBURST;
  wire logic [31:0] HWDATA;
  wire logic [31:0] HRDATA;
  wire logic HREADY;

  logic [31:0] refMem [256];
  adrPhaseT adrQ[$];
  logic pendWrite;
  logic [7:0] pendIdx;
  int ackCount;
  int cycles;
  logic [31:0] rng = 32'd33711;

  busBridge #(.xlen(32), .wordsPerLine(wpl)) busBridge_i (.*);

  ahbMemModel #(.maxWait(maxWait)) memModel_i (.*);

  always #20 HCLK = ~HCLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic checkEq(input string testName, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("** Error: %s: expected %h, actual %h", testName, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus monitor, reference memory and ack count
  ////////////////////////////////////////////////////////////

  always @(posedge HCLK) begin
    if (!HRESETn) begin
      pendWrite <= 1'b0;
      ackCount  <= 0;
    end else begin
      if (cacheBusAck) ackCount <= ackCount + 1;
      if (HREADY) begin
        if (pendWrite) refMem[pendIdx] <= HWDATA;
        pendWrite <= HTRANS[1] && HWRITE;
        pendIdx   <= HADDR[9:2];
        if (HTRANS[1]) adrQ.push_back({HADDR, HTRANS, HWRITE, HBURST});
      end
    end
  end

  // Waited transfer keeps its address and type
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!HREADY && HTRANS[1]) |=> (HADDR == $past(HADDR) && HTRANS == $past(HTRANS)))
  else begin
    $display("** Error: HADDR or HTRANS changed while HREADY was low");
    $display("RESULT: FAIL");
    $fatal(1);
  end

  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the bridge did not finish within %0d cycles", cycleLimit);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, called on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic uncachedAccess(input string testName, input busPkg::busRwT rw,
                                input logic [31:0] adr, input logic [31:0] wdata,
                                input int busyHold);
    adrQ.delete();
    busRw = rw;
    cpuAdr = adr;
    cpuWriteData = wdata;
    cpuBusy = (busyHold > 0);
    @(negedge HCLK);
    while (busStall) @(negedge HCLK);
    // Completion state is held for as long as the CPU is busy
    for (int i = 0; i < busyHold; i++) begin
      checkEq({testName, " busCommitted"}, 32'd1, 32'(busCommitted));
      @(negedge HCLK);
    end
    busRw = '0;
    cpuBusy = 1'b0;
    @(negedge HCLK);
    checkEq({testName, " address phases"}, 32'd1, 32'(adrQ.size()));
    checkEq({testName, " HADDR"}, adr, adrQ[0].addr);
    checkEq({testName, " HTRANS"}, 32'(busPkg::NONSEQ), 32'(adrQ[0].trans));
    checkEq({testName, " HBURST"}, 32'(busPkg::burstSingle), 32'(adrQ[0].burst));
    checkEq({testName, " HWRITE"}, 32'(rw[0]), 32'(adrQ[0].write));
  endtask

  // Returns on the falling edge where cacheBusAck is seen
  task automatic lineRequest(input busPkg::busRwT rw, input logic [31:0] adr,
                             input busPkg::busRwT nextRw, input logic [31:0] nextAdr);
    cacheBusRw = rw;
    cacheLineAdr = adr;
    @(negedge HCLK);
    while (!cacheBusAck) @(negedge HCLK);
    cacheBusRw = nextRw;
    cacheLineAdr = nextAdr;
  endtask

  task automatic checkBurst(input string testName, input int first,
                            input logic [31:0] base, input logic write);
    adrPhaseT ph;
    for (int i = 0; i < wpl; i++) begin
      ph = adrQ[first + i];
      checkEq({testName, " HADDR"}, base + 32'(4 * i), ph.addr);
      checkEq({testName, " HTRANS"},
              32'(i == 0 ? busPkg::NONSEQ : busPkg::SEQ), 32'(ph.trans));
      checkEq({testName, " HBURST"}, 32'(busPkg::burstIncr4), 32'(ph.burst));
      checkEq({testName, " HWRITE"}, 32'(write), 32'(ph.write));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int acks0;
    for (int i = 0; i < 256; i++) begin
      refMem[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h9E37_79B1);
    end
    cycles = 0;
    HRESETn = 1'b0;
    busRw = '0;
    cpuAdr = '0;
    cpuWriteData = '0;
    cpuBusy = 1'b0;
    cacheBusRw = '0;
    cacheLineAdr = '0;
    evictLine = '0;
    repeat (4) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);

    // Idle outputs out of reset
    checkEq("reset HTRANS", 32'(busPkg::IDLE), 32'(HTRANS));
    checkEq("reset busCommitted", 32'd0, 32'(busCommitted));
    checkEq("reset busStall", 32'd0, 32'(busStall));
    checkEq("reset cacheBusAck", 32'd0, 32'(cacheBusAck));

    uncachedAccess("uncached read", 2'b10, 32'h40, 32'h0, 0);
    checkEq("uncached read data", refMem[8'h10], readData);

    rng = xorshift32(rng);
    uncachedAccess("uncached write", 2'b01, 32'h44, rng, 3);
    checkEq("uncached write mem", rng, memModel_i.mem[8'h11]);
    uncachedAccess("uncached readback", 2'b10, 32'h44, 32'h0, 0);
    checkEq("uncached readback data", rng, readData);

    // Line fill
    adrQ.delete();
    acks0 = ackCount;
    lineRequest(2'b10, 32'h100, 2'b00, 32'h0);
    @(negedge HCLK);
    checkEq("fill acks", 32'd1, 32'(ackCount - acks0));
    checkEq("fill address phases", 32'(wpl), 32'(adrQ.size()));
    checkBurst("fill", 0, 32'h100, 1'b0);
    for (int i = 0; i < wpl; i++) begin
      checkEq("fill data", refMem[8'h40 + 8'(i)], fetchedLine[i*32 +: 32]);
    end

    // Line eviction
    for (int i = 0; i < wpl; i++) begin
      rng = xorshift32(rng);
      evictLine[i*32 +: 32] = rng;
    end
    adrQ.delete();
    acks0 = ackCount;
    lineRequest(2'b01, 32'h180, 2'b00, 32'h0);
    @(negedge HCLK);
    checkEq("evict acks", 32'd1, 32'(ackCount - acks0));
    checkBurst("evict", 0, 32'h180, 1'b1);
    for (int i = 0; i < wpl; i++) begin
      checkEq("evict mem", evictLine[i*32 +: 32], memModel_i.mem[8'h60 + 8'(i)]);
    end

    // Eviction chained straight into a fetch of the same line
    for (int i = 0; i < wpl; i++) begin
      rng = xorshift32(rng);
      evictLine[i*32 +: 32] = rng;
    end
    adrQ.delete();
    acks0 = ackCount;
    lineRequest(2'b01, 32'h200, 2'b10, 32'h200);
    lineRequest(2'b10, 32'h200, 2'b00, 32'h0);
    @(negedge HCLK);
    checkEq("chain acks", 32'd2, 32'(ackCount - acks0));
    checkEq("chain address phases", 32'(2 * wpl), 32'(adrQ.size()));
    checkBurst("chain evict", 0, 32'h200, 1'b1);
    checkBurst("chain fetch", wpl, 32'h200, 1'b0);
    for (int i = 0; i < wpl; i++) begin
      checkEq("chain evict data", evictLine[i*32 +: 32], refMem[8'h80 + 8'(i)]);
      checkEq("chain fetch data", refMem[8'h80 + 8'(i)], fetchedLine[i*32 +: 32]);
    end

    repeat (2) @(negedge HCLK);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/busPkg.sv
hdl/busCacheFsm.sv
hdl/busAddrGen.sv
hdl/busDataPath.sv
hdl/busBridge.sv
bench/ahbMemModel.sv
bench/busBridgeTb.sv

// ==== Makefile ====
# Verilator build and run for the bus bridge testbench

TOP := busBridgeTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
